//--- rtl/ppu_pkg.sv
package ppu_pkg;

    // raster geometry
    localparam int NUM_COLS = 341;
    localparam int NUM_ROWS = 262;
    localparam int VIS_ROWS = 240;
    localparam int VIS_COLS = 256;
    localparam int PRE_ROW = 261;

    // horizontal phase boundaries
    localparam int SP_PRE_START = 257;
    localparam int TL_PRE_START = 321;

    // object table and sprite limits
    localparam int SPRITE_HEIGHT = 8;
    localparam int NUM_SPRITES = 64;
    localparam int SLOTS = 8;

    // second pattern table starts at 4 KiB
    localparam logic [12:0] PATT_RIGHT_BASE = 13'h1000;

    typedef enum logic [2:0] {
        SL_PRE_CYC,
        IDLE_CYC,
        SP_PRE_CYC,
        GARB_CYC,
        TL_PRE_CYC
    } hs_state_t;

    typedef enum logic {
        LEFT_TBL,
        RIGHT_TBL
    } pattern_tbl_t;

    // object attribute byte as stored in the table
    typedef struct packed {
        logic       flip_v;
        logic       flip_h;
        logic       behind_bg;
        logic [2:0] unused;
        logic [1:0] palette;
    } sprite_attr_t;

    typedef struct packed {
        logic         active;
        logic [7:0]   y_pos;
        logic [7:0]   tile_idx;
        sprite_attr_t attribute;
        logic [7:0]   x_pos;
        logic [7:0]   bitmap_hi;
        logic [7:0]   bitmap_lo;
    } second_oam_t;

    typedef struct packed {
        logic       opaque;
        logic [1:0] palette;
        logic [1:0] color;
        logic       behind_bg;
    } sprite_px_t;

endpackage

//--- rtl/raster_timing.sv
module raster_timing
    import ppu_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    output logic      clk_en,
    output logic [8:0] row,
    output logic [8:0] col,
    output hs_state_t hs_state
);
    logic [1:0] div_cnt;
    logic       render_row;

    // picture clock is the master clock divided by four
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= 2'd0;
        end else begin
            div_cnt <= div_cnt + 2'd1;
        end
    end

    assign clk_en = (div_cnt == 2'd3);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            col <= 9'd0;
            row <= 9'd0;
        end else if (clk_en) begin
            if (col == 9'(NUM_COLS - 1)) begin
                col <= 9'd0;
                row <= (row == 9'(NUM_ROWS - 1)) ? 9'd0 : row + 9'd1;
            end else begin
                col <= col + 9'd1;
            end
        end
    end

    // visible lines plus the pre-render line fetch sprites
    assign render_row = (row < 9'(VIS_ROWS)) || (row == 9'(PRE_ROW));

    always_comb begin
        if (!render_row) begin
            hs_state = GARB_CYC;
        end else if (col < 9'(NUM_SPRITES * 4)) begin
            hs_state = SL_PRE_CYC;
        end else if (col < 9'(SP_PRE_START)) begin
            hs_state = IDLE_CYC;
        end else if (col < 9'(SP_PRE_START + SLOTS)) begin
            hs_state = SP_PRE_CYC;
        end else if (col < 9'(TL_PRE_START)) begin
            hs_state = GARB_CYC;
        end else begin
            hs_state = TL_PRE_CYC;
        end
    end

    a_raster_bounds: assert property (@(posedge clk) disable iff (!rst_n)
        (col < 9'(NUM_COLS)) && (row < 9'(NUM_ROWS)));

endmodule

//--- rtl/temp_oam.sv
module temp_oam
    import ppu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clk_en,
    input  logic        clr,
    input  logic        wr,
    input  second_oam_t wr_data,
    input  logic [2:0]  rd_idx,
    output second_oam_t rd_data,
    output logic        overflow
);
    second_oam_t slots [SLOTS];
    logic [3:0]  wr_ptr;
    logic        ovf_pend;
    logic        clr_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SLOTS; i++) begin
                slots[i] <= '0;
            end
            wr_ptr   <= 4'd0;
            ovf_pend <= 1'b0;
            clr_q    <= 1'b0;
            overflow <= 1'b0;
        end else if (clk_en) begin
            clr_q <= clr;
            if (clr) begin
                for (int i = 0; i < SLOTS; i++) begin
                    slots[i] <= '0;
                end
                wr_ptr   <= 4'd0;
                ovf_pend <= 1'b0;
            end else if (wr) begin
                if (wr_ptr < 4'(SLOTS)) begin
                    slots[wr_ptr[2:0]] <= wr_data;
                    wr_ptr             <= wr_ptr + 4'd1;
                end else begin
                    // ninth hit on this line
                    ovf_pend <= 1'b1;
                end
            end
            // flag for the line just scanned is published when its clear begins,
            // so it is stable while that line is drawn
            if (clr && !clr_q) begin
                overflow <= ovf_pend;
            end
        end
    end

    assign rd_data = slots[rd_idx];

    a_no_clr_wr: assert property (@(posedge clk) disable iff (!rst_n) !(clr && wr));

endmodule

//--- rtl/sp_eval.sv
module sp_eval
    import ppu_pkg::*;
(
    input  logic         clk,
    input  logic         clk_en,
    input  logic         rst_n,

    // current raster position and phase
    input  logic [8:0]   row,
    input  logic [8:0]   col,
    input  hs_state_t    hs_state,
    input  pattern_tbl_t patt_tbl,

    // object table
    output logic [7:0]   oam_addr,
    input  logic [7:0]   oam_data,

    // temporary buffer
    output logic         temp_oam_clr,
    output logic         temp_oam_wr,
    output second_oam_t  temp_oam_wr_data,
    output logic [2:0]   temp_oam_rd_idx,
    input  second_oam_t  temp_oam_rd_data,

    // secondary object memory in the renderer
    output logic         sec_oam_clr,
    output logic         sec_oam_wr,
    output second_oam_t  sec_oam_wr_data,

    // character ROM
    output logic [12:0]  chr_rom_addr1,
    output logic [12:0]  chr_rom_addr2,
    input  logic [7:0]   chr_rom_data1,
    input  logic [7:0]   chr_rom_data2,
    output logic         chr_rom_re
);
    logic [8:0]  next_row;
    logic [8:0]  oam_y;
    logic        y_hit;
    second_oam_t curr_sprite_in;
    second_oam_t curr_sprite;
    logic [8:0]  sp_pre_col;
    logic [8:0]  row_in_tile;
    logic [2:0]  tile_row;
    logic [12:0] pattbl_off;

    // sprites are evaluated one line ahead, pre-render line feeds line 0
    assign next_row = (row == 9'(PRE_ROW)) ? 9'd0 : row + 9'd1;

    // sprite being assembled across its four table bytes
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            curr_sprite <= '0;
        end else if (clk_en) begin
            curr_sprite <= curr_sprite_in;
        end
    end

    // byte col of the table during the scan
    assign oam_addr = col[7:0];

    assign oam_y = {1'b0, oam_data};
    assign y_hit = (oam_y <= next_row) && (next_row < oam_y + 9'(SPRITE_HEIGHT));

    assign temp_oam_wr_data = curr_sprite_in;

    // slot index during the fetch window
    assign sp_pre_col      = col - 9'(SP_PRE_START);
    assign temp_oam_rd_idx = sp_pre_col[2:0];

    assign pattbl_off = (patt_tbl == RIGHT_TBL) ? PATT_RIGHT_BASE : 13'h0000;

    // line within the tile, upside down when flipped
    assign row_in_tile = next_row - {1'b0, temp_oam_rd_data.y_pos};
    assign tile_row    = temp_oam_rd_data.attribute.flip_v ? 3'd7 - row_in_tile[2:0]
                                                          : row_in_tile[2:0];

    // 16 bytes per tile, high plane 8 bytes after the low one
    assign chr_rom_addr1 = pattbl_off + {1'b0, temp_oam_rd_data.tile_idx, 1'b0, tile_row};
    assign chr_rom_addr2 = chr_rom_addr1 + 13'd8;

    always_comb begin
        curr_sprite_in  = '0;
        temp_oam_clr    = 1'b0;
        temp_oam_wr     = 1'b0;
        sec_oam_clr     = 1'b0;
        sec_oam_wr      = 1'b0;
        sec_oam_wr_data = '0;
        chr_rom_re      = 1'b0;

        case (hs_state)
            SL_PRE_CYC: begin
                case (col[1:0])
                    2'd0: begin
                        if (y_hit) begin
                            curr_sprite_in.active = 1'b1;
                            curr_sprite_in.y_pos  = oam_data;
                        end
                    end
                    2'd1: begin
                        if (curr_sprite.active) begin
                            curr_sprite_in          = curr_sprite;
                            curr_sprite_in.tile_idx = oam_data;
                        end
                    end
                    2'd2: begin
                        if (curr_sprite.active) begin
                            curr_sprite_in           = curr_sprite;
                            curr_sprite_in.attribute = sprite_attr_t'(oam_data);
                        end
                    end
                    default: begin
                        if (curr_sprite.active) begin
                            curr_sprite_in       = curr_sprite;
                            curr_sprite_in.x_pos = oam_data;
                            temp_oam_wr          = 1'b1;
                        end
                    end
                endcase
            end
            IDLE_CYC: begin
                sec_oam_clr = 1'b1;
            end
            SP_PRE_CYC: begin
                // one slot per column, inactive slots pass through as empty
                chr_rom_re                = 1'b1;
                sec_oam_wr                = 1'b1;
                sec_oam_wr_data           = temp_oam_rd_data;
                sec_oam_wr_data.bitmap_lo = chr_rom_data1;
                sec_oam_wr_data.bitmap_hi = chr_rom_data2;
            end
            TL_PRE_CYC: begin
                temp_oam_clr = 1'b1;
            end
            default: begin
            end
        endcase
    end

    // ROM reads stay inside the eight fetch columns set by the decoder
    a_chr_window: assert property (@(posedge clk) disable iff (!rst_n)
        chr_rom_re |-> (col >= 9'(SP_PRE_START)) && (col < 9'(SP_PRE_START + SLOTS)));

endmodule

//--- rtl/sp_render.sv
module sp_render
    import ppu_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        clk_en,
    input  logic [8:0]  row,
    input  logic [8:0]  col,
    input  logic        sec_oam_clr,
    input  logic        sec_oam_wr,
    input  second_oam_t sec_oam_wr_data,
    output logic        px_valid,
    output logic [8:0]  px_row,
    output logic [8:0]  px_col,
    output sprite_px_t  sprite_px
);
    second_oam_t sec_mem [SLOTS];
    logic [3:0]  wr_cnt;
    logic        visible;
    sprite_px_t  px_next;

    // pixel one slot would draw at column c, zero when transparent
    function automatic sprite_px_t slot_pixel(input second_oam_t s, input logic [8:0] c);
        logic [8:0] dx;
        logic [2:0] bit_idx;
        sprite_px_t p;
        dx      = c - {1'b0, s.x_pos};
        bit_idx = s.attribute.flip_h ? dx[2:0] : 3'd7 - dx[2:0];
        p       = '0;
        // sprites are square, width equals height
        if (s.active && (dx < 9'(SPRITE_HEIGHT))) begin
            p.color = {s.bitmap_hi[bit_idx], s.bitmap_lo[bit_idx]};
            if (p.color != 2'b00) begin
                p.opaque    = 1'b1;
                p.palette   = s.attribute.palette;
                p.behind_bg = s.attribute.behind_bg;
            end
        end
        return p;
    endfunction

    // secondary memory, only the first eight writes after a clear land
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < SLOTS; i++) begin
                sec_mem[i] <= '0;
            end
            wr_cnt <= 4'd0;
        end else if (clk_en) begin
            if (sec_oam_clr) begin
                for (int i = 0; i < SLOTS; i++) begin
                    sec_mem[i] <= '0;
                end
                wr_cnt <= 4'd0;
            end else if (sec_oam_wr && (wr_cnt < 4'(SLOTS))) begin
                sec_mem[wr_cnt[2:0]] <= sec_oam_wr_data;
                wr_cnt               <= wr_cnt + 4'd1;
            end
        end
    end

    assign visible = (row < 9'(VIS_ROWS)) && (col < 9'(VIS_COLS));

    // walk down so the lowest opaque slot wins
    always_comb begin
        sprite_px_t cand;
        px_next = '0;
        for (int i = SLOTS - 1; i >= 0; i--) begin
            cand = slot_pixel(sec_mem[i], col);
            if (cand.opaque) begin
                px_next = cand;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            px_valid <= 1'b0;
        end else if (clk_en) begin
            px_valid <= visible;
        end
    end

    always_ff @(posedge clk) begin
        if (clk_en) begin
            px_row    <= row;
            px_col    <= col;
            sprite_px <= px_next;
        end
    end

    a_wr_cnt_max: assert property (@(posedge clk) disable iff (!rst_n) wr_cnt <= 4'(SLOTS));

endmodule

//--- rtl/sprite_unit.sv
module sprite_unit
    import ppu_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  pattern_tbl_t patt_tbl,
    input  logic [7:0]   oam_data,
    input  logic [7:0]   chr_rom_data1,
    input  logic [7:0]   chr_rom_data2,
    output logic [7:0]   oam_addr,
    output logic [12:0]  chr_rom_addr1,
    output logic [12:0]  chr_rom_addr2,
    output logic         chr_rom_re,
    output logic         px_valid,
    output logic [8:0]   px_row,
    output logic [8:0]   px_col,
    output sprite_px_t   sprite_px,
    output logic         sprite_overflow
);
    logic        clk_en;
    logic [8:0]  row;
    logic [8:0]  col;
    hs_state_t   hs_state;

    logic        temp_oam_clr;
    logic        temp_oam_wr;
    second_oam_t temp_oam_wr_data;
    logic [2:0]  temp_oam_rd_idx;
    second_oam_t temp_oam_rd_data;

    logic        sec_oam_clr;
    logic        sec_oam_wr;
    second_oam_t sec_oam_wr_data;

    raster_timing u_timing (
        .clk      (clk),
        .rst_n    (rst_n),
        .clk_en   (clk_en),
        .row      (row),
        .col      (col),
        .hs_state (hs_state)
    );

    temp_oam u_temp_oam (
        .clk      (clk),
        .rst_n    (rst_n),
        .clk_en   (clk_en),
        .clr      (temp_oam_clr),
        .wr       (temp_oam_wr),
        .wr_data  (temp_oam_wr_data),
        .rd_idx   (temp_oam_rd_idx),
        .rd_data  (temp_oam_rd_data),
        .overflow (sprite_overflow)
    );

    sp_eval u_eval (
        .clk              (clk),
        .clk_en           (clk_en),
        .rst_n            (rst_n),
        .row              (row),
        .col              (col),
        .hs_state         (hs_state),
        .patt_tbl         (patt_tbl),
        .oam_addr         (oam_addr),
        .oam_data         (oam_data),
        .temp_oam_clr     (temp_oam_clr),
        .temp_oam_wr      (temp_oam_wr),
        .temp_oam_wr_data (temp_oam_wr_data),
        .temp_oam_rd_idx  (temp_oam_rd_idx),
        .temp_oam_rd_data (temp_oam_rd_data),
        .sec_oam_clr      (sec_oam_clr),
        .sec_oam_wr       (sec_oam_wr),
        .sec_oam_wr_data  (sec_oam_wr_data),
        .chr_rom_addr1    (chr_rom_addr1),
        .chr_rom_addr2    (chr_rom_addr2),
        .chr_rom_data1    (chr_rom_data1),
        .chr_rom_data2    (chr_rom_data2),
        .chr_rom_re       (chr_rom_re)
    );

    sp_render u_render (
        .clk             (clk),
        .rst_n           (rst_n),
        .clk_en          (clk_en),
        .row             (row),
        .col             (col),
        .sec_oam_clr     (sec_oam_clr),
        .sec_oam_wr      (sec_oam_wr),
        .sec_oam_wr_data (sec_oam_wr_data),
        .px_valid        (px_valid),
        .px_row          (px_row),
        .px_col          (px_col),
        .sprite_px       (sprite_px)
    );

endmodule

//--- verif/tb_clk_gen.sv
module tb_clk_gen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    // 20 ns period
    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    // reset held low for three rising edges
    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

//--- verif/sprite_unit_tb.sv
module sprite_unit_tb
    import ppu_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_FRAMES    = 3;
    localparam int RESET_TIMEOUT = 100;
    localparam int PIXEL_TIMEOUT = 40000;

    logic         clk;
    logic         rst_n;
    pattern_tbl_t patt_tbl;
    logic [7:0]   oam_data;
    logic [7:0]   chr_rom_data1;
    logic [7:0]   chr_rom_data2;
    logic [7:0]   oam_addr;
    logic [12:0]  chr_rom_addr1;
    logic [12:0]  chr_rom_addr2;
    logic         chr_rom_re;
    logic         px_valid;
    logic [8:0]   px_row;
    logic [8:0]   px_col;
    sprite_px_t   sprite_px;
    logic         sprite_overflow;

    // object table and character ROM read asynchronously
    logic [7:0] oam_mem [256];
    logic [7:0] chr_mem [8192];

    // model state for the line being checked
    int   line_idx [SLOTS];
    int   line_n;
    int   line_hits;

    int   pixel_errors;
    int   pos_errors;
    int   ovf_errors;
    int   reset_errors;
    int   other_errors;
    logic timed_out;
    logic prev_valid;
    logic [8:0] prev_row;
    logic [8:0] prev_col;
    int   exp_r;
    int   exp_c;
    int   wait_cnt;

    tb_clk_gen u_clk_gen (
        .clk   (clk),
        .rst_n (rst_n)
    );

    sprite_unit uut (
        .clk             (clk),
        .rst_n           (rst_n),
        .patt_tbl        (patt_tbl),
        .oam_data        (oam_data),
        .chr_rom_data1   (chr_rom_data1),
        .chr_rom_data2   (chr_rom_data2),
        .oam_addr        (oam_addr),
        .chr_rom_addr1   (chr_rom_addr1),
        .chr_rom_addr2   (chr_rom_addr2),
        .chr_rom_re      (chr_rom_re),
        .px_valid        (px_valid),
        .px_row          (px_row),
        .px_col          (px_col),
        .sprite_px       (sprite_px),
        .sprite_overflow (sprite_overflow)
    );

    assign oam_data = oam_mem[oam_addr];

    // ROM returns pattern bytes only while the read enable is high
    assign chr_rom_data1 = chr_rom_re ? chr_mem[chr_rom_addr1] : 8'h00;
    assign chr_rom_data2 = chr_rom_re ? chr_mem[chr_rom_addr2] : 8'h00;

    // about one y in four lands near a cluster so some lines get crowded
    function automatic logic [7:0] random_y(input int center);
        if ($urandom_range(0, 3) == 0) begin
            return 8'(center + int'($urandom_range(0, 5)));
        end
        return 8'($urandom);
    endfunction

    // new table for the next frame written one byte per clock
    task automatic rewrite_table();
        int center;
        center = int'($urandom_range(0, 223));
        for (int j = 0; j < 256; j++) begin
            @(posedge clk);
            oam_mem[j] <= (j % 4 == 0) ? random_y(center) : 8'($urandom);
        end
        @(posedge clk);
        patt_tbl <= pattern_tbl_t'(1'($urandom));
    endtask

    // first eight entries covering line r and the total hit count
    task automatic build_line(input int r, input logic empty);
        int y;
        line_n    = 0;
        line_hits = 0;
        for (int i = 0; i < NUM_SPRITES; i++) begin
            y = int'(oam_mem[4 * i]);
            if (!empty && (y <= r) && (r < y + 8)) begin
                if (line_n < 8) begin
                    line_idx[line_n] = i;
                    line_n++;
                end
                line_hits++;
            end
        end
    endtask

    function automatic sprite_px_t model_pixel(input int r, input int c);
        sprite_px_t p;
        logic       found;
        logic [7:0] attr;
        logic [7:0] lo;
        logic [7:0] hi;
        int         i;
        int         x;
        int         tline;
        int         addr;
        int         b;
        p     = '0;
        found = 1'b0;
        for (int k = 0; k < line_n; k++) begin
            i    = line_idx[k];
            attr = oam_mem[4 * i + 2];
            x    = int'(oam_mem[4 * i + 3]);
            if (!found && (c >= x) && (c < x + 8)) begin
                tline = r - int'(oam_mem[4 * i]);
                if (attr[7]) begin
                    tline = 7 - tline;
                end
                addr = ((patt_tbl == RIGHT_TBL) ? 4096 : 0) + int'(oam_mem[4 * i + 1]) * 16 + tline;
                lo   = chr_mem[addr];
                hi   = chr_mem[addr + 8];
                b    = attr[6] ? (c - x) : 7 - (c - x);
                if (hi[b] || lo[b]) begin
                    found       = 1'b1;
                    p.opaque    = 1'b1;
                    p.palette   = attr[1:0];
                    p.color     = {hi[b], lo[b]};
                    p.behind_bg = attr[5];
                end
            end
        end
        return p;
    endfunction

    task automatic check_pixel(input sprite_px_t exp, input sprite_px_t got, input int r,
                               input int c);
        if (got !== exp) begin
            pixel_errors++;
            $display("Error: sprite_px at row %0d col %0d expected %h got %h", r, c, exp, got);
        end
    endtask

    task automatic check_position(input string name, input logic [8:0] exp,
                                  input logic [8:0] got);
        if (got !== exp) begin
            pos_errors++;
            $display("Error: %s expected %h got %h", name, exp, got);
        end
    endtask

    task automatic check_overflow(input logic exp, input logic got, input int r);
        if (got !== exp) begin
            ovf_errors++;
            $display("Error: sprite_overflow on line %0d expected %h got %h", r, exp, got);
        end
    endtask

    task automatic check_low(input string name, input logic got);
        if (got !== 1'b0) begin
            reset_errors++;
            $display("Error: %s after reset expected 0 got %h", name, got);
        end
    endtask

    // returns at the negedge where a new valid pixel shows up
    task automatic wait_pixel(output logic timeout);
        int   cycles;
        logic got;
        cycles  = 0;
        got     = 1'b0;
        timeout = 1'b0;
        while (!got && !timeout) begin
            @(negedge clk);
            got        = px_valid && (!prev_valid || (px_row != prev_row) || (px_col != prev_col));
            prev_valid = px_valid;
            prev_row   = px_row;
            prev_col   = px_col;
            cycles++;
            if (!got && (cycles > PIXEL_TIMEOUT)) begin
                timeout = 1'b1;
            end
        end
    endtask

    initial begin
        void'($urandom(32'hb51b));
        pixel_errors = 0;
        pos_errors   = 0;
        ovf_errors   = 0;
        reset_errors = 0;
        other_errors = 0;
        timed_out    = 1'b0;
        prev_valid   = 1'b0;
        prev_row     = '0;
        prev_col     = '0;
        line_n       = 0;
        line_hits    = 0;
        for (int j = 0; j < 8192; j++) begin
            chr_mem[j] = 8'($urandom);
        end
        wait_cnt = int'($urandom_range(0, 223));
        for (int j = 0; j < 256; j++) begin
            oam_mem[j] = (j % 4 == 0) ? random_y(wait_cnt) : 8'($urandom);
        end
        patt_tbl = pattern_tbl_t'(1'($urandom));

        wait_cnt = 0;
        while (!rst_n && !timed_out) begin
            @(negedge clk);
            wait_cnt++;
            if (wait_cnt > RESET_TIMEOUT) begin
                timed_out = 1'b1;
            end
        end
        if (timed_out) begin
            other_errors++;
            $display("reset was never released");
        end else begin
            check_low("px_valid", px_valid);
            check_low("sprite_overflow", sprite_overflow);
            check_low("chr_rom_re", chr_rom_re);
        end

        for (int f = 0; (f < NUM_FRAMES) && !timed_out; f++) begin
            exp_r = 0;
            exp_c = 0;
            while ((exp_r < VIS_ROWS) && !timed_out) begin
                wait_pixel(timed_out);
                if (timed_out) begin
                    other_errors++;
                    $display("no pixel arrived for frame %0d line %0d", f, exp_r);
                end else begin
                    check_position("px_row", 9'(exp_r), px_row);
                    check_position("px_col", 9'(exp_c), px_col);
                    // line 0 of the first frame had no evaluation before it
                    if (px_col == 9'd0) begin
                        build_line(int'(px_row), (f == 0) && (px_row == 9'd0));
                        check_overflow(line_hits > 8, sprite_overflow, int'(px_row));
                    end
                    check_pixel(model_pixel(int'(px_row), int'(px_col)), sprite_px,
                                int'(px_row), int'(px_col));
                    exp_c++;
                    if (exp_c == VIS_COLS) begin
                        exp_c = 0;
                        exp_r++;
                    end
                end
            end
            if (!timed_out && (f < NUM_FRAMES - 1)) begin
                // step into the vertical blank before touching the table
                repeat (NUM_COLS * 4) @(posedge clk);
                rewrite_table();
            end
        end

        $display("errors: pixel %0d, position %0d, overflow %0d, reset %0d, other %0d",
                 pixel_errors, pos_errors, ovf_errors, reset_errors, other_errors);
        if ((pixel_errors + pos_errors + ovf_errors + reset_errors + other_errors) == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
rtl/ppu_pkg.sv
rtl/raster_timing.sv
rtl/temp_oam.sv
rtl/sp_eval.sv
rtl/sp_render.sv
rtl/sprite_unit.sv
verif/tb_clk_gen.sv
verif/sprite_unit_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -Wno-fatal
TOP       ?= sprite_unit_tb
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "Test completed successfully" $(LOG); then echo "simulation incomplete"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
